// File: source/fetch_pkg.sv
package fetch_pkg;

  // ==============================
  // fetch data path geometry
  // ==============================

  localparam int ADDR_W         = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  // byte offset within one line
  localparam int OFFSET_W       = 4;
  localparam int LINE_ADDR_W    = ADDR_W - OFFSET_W;

  // first fetch address out of reset
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // ==============================
  // stream payloads
  // ==============================

  // line request, offset bits dropped
  typedef struct packed {
    logic [LINE_ADDR_W-1:0] line_addr;
  } line_req_t;

  // line response, nonzero resp marks a bus error
  typedef struct packed {
    logic [LINE_W-1:0] data;
    logic [1:0]        resp;
  } line_resp_t;

  // one fetched instruction for the decode stage
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [31:0]       inst;
    logic              err;
  } fetch_out_t;

endpackage

// File: source/rv_inst_pkg.sv
package rv_inst_pkg;

  // ==============================
  // RV32 base opcodes
  // ==============================

  localparam int INST_W = 32;

  // jal rd, offset
  localparam logic [6:0] OP_JAL = 7'b110_1111;
  // addi and the other register-immediate ops
  localparam logic [6:0] OP_IMM = 7'b001_0011;

  // ==============================
  // instruction formats
  // ==============================

  // only the opcode is decoded here
  typedef struct packed {
    logic [24:0] rest;
    logic [6:0]  opcode;
  } generic_fmt_t;

  // J-type, immediate bits scattered as in the spec
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jal_fmt_t;

  // ==============================
  // one instruction word, two views
  // ==============================

  typedef union packed {
    generic_fmt_t gen;
    jal_fmt_t     jal;
  } inst_word_u;

endpackage

// File: source/line_buffer.sv
module line_buffer import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_i,
  input  line_resp_t        push_line_i,
  input  logic              pop_i,
  input  logic              flush_i,
  output logic              full_o,
  output logic              empty_o,
  output logic [LINE_W-1:0] head_line_o,
  output logic              head_err_o
);

  // two lines, msb of each pointer is the wrap bit
  line_resp_t mem_q [2];
  logic [1:0] wr_ptr_q;
  logic [1:0] rd_ptr_q;
  line_resp_t head;

  // ==============================
  // pointers
  // ==============================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= 2'd0;
      rd_ptr_q <= 2'd0;
    end else if (flush_i) begin
      wr_ptr_q <= 2'd0;
      rd_ptr_q <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
    end
  end

  assign empty_o = (rd_ptr_q == wr_ptr_q);
  assign full_o  = (rd_ptr_q == {~wr_ptr_q[1], wr_ptr_q[0]});

  // ==============================
  // storage
  // ==============================

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q[0]] <= push_line_i;
    end
  end

  // write bypass, an empty buffer shows the incoming line at once
  always_comb begin
    if (empty_o && push_i) begin
      head = push_line_i;
    end else begin
      head = mem_q[rd_ptr_q[0]];
    end
  end

  assign head_line_o = head.data;
  assign head_err_o  = |head.resp;

  // a pop on an empty buffer only works through the bypass
  pop_not_empty_a : assert property (@(posedge clk) disable iff (rst_n)
    pop_i |-> !empty_o || push_i);

endmodule

// File: source/inst_select.sv
module inst_select import fetch_pkg::*, rv_inst_pkg::*; (
  input  logic [ADDR_W-1:0] pc_i,
  input  logic [LINE_W-1:0] line_i,
  output logic [INST_W-1:0] inst_o,
  output logic [ADDR_W-1:0] next_pc_o
);

  logic [WORDS_PER_LINE-1:0][INST_W-1:0] words;
  logic [OFFSET_W-3:0]                   word_idx;
  inst_word_u                            word;
  logic                                  is_jal;
  logic [ADDR_W-1:0]                     j_imm;

  // ==============================
  // word select
  // ==============================

  assign words    = line_i;
  // word index within the line, pc is word aligned
  assign word_idx = pc_i[OFFSET_W-1:2];
  assign word     = words[word_idx];
  assign inst_o   = word;

  // ==============================
  // jal predecode
  // ==============================

  assign is_jal = (word.gen.opcode == OP_JAL);

  // reassemble the J immediate, bit 0 is always zero
  assign j_imm = {
    {(ADDR_W - 20){word.jal.imm20}},
    word.jal.imm19_12,
    word.jal.imm11,
    word.jal.imm10_1,
    1'b0
  };

  always_comb begin
    if (is_jal) begin
      next_pc_o = pc_i + j_imm;
    end else begin
      next_pc_o = pc_i + ADDR_W'(4);
    end
  end

endmodule

// File: source/fetch_ctrl.sv
module fetch_ctrl import fetch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // line request stream
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output line_req_t             req_o,
  // line response stream
  input  logic                  resp_valid_i,
  output logic                  resp_ready_o,
  // instruction output stream
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output fetch_out_t            out_o,
  // back end redirect
  input  logic                  redirect_valid_i,
  input  logic [ADDR_W-1:0]     redirect_pc_i,
  // line buffer control
  output logic                  buf_push_o,
  output logic                  buf_pop_o,
  output logic                  buf_flush_o,
  input  logic                  buf_full_i,
  input  logic                  buf_empty_i,
  input  logic                  head_err_i,
  // from word select
  input  logic [ADDR_W-1:0]     next_pc_i,
  input  logic [31:0]           sel_inst_i,
  output logic [ADDR_W-1:0]     pc_o
);

  typedef enum logic {
    S_IDLE,
    S_WAIT_RESP
  } req_state_e;

  req_state_e             state_q;
  logic                   req_valid_q;
  line_req_t              req_q;
  logic [LINE_ADDR_W-1:0] req_line_q;
  logic                   stale_q;
  logic [ADDR_W-1:0]      pc_q;

  logic                   req_fire;
  logic                   resp_fire;
  logic                   out_fire;
  logic                   head_valid;
  logic                   req_raise;
  logic                   line_step;
  logic                   jump_away;
  logic                   flush;
  logic [LINE_ADDR_W-1:0] pc_line;
  logic [LINE_ADDR_W-1:0] next_line;

  // ==============================
  // handshakes
  // ==============================

  assign req_fire  = req_valid_o && req_ready_i;
  assign resp_fire = resp_valid_i && resp_ready_o;
  assign out_fire  = out_valid_o && out_ready_i;

  assign pc_line   = pc_q[ADDR_W-1:OFFSET_W];
  assign next_line = next_pc_i[ADDR_W-1:OFFSET_W];

  // stale lines and lines racing a redirect never enter the buffer
  assign buf_push_o = resp_fire && !stale_q && !redirect_valid_i;

  // head holds the pc line whenever the buffer has data
  assign head_valid  = !buf_empty_i || buf_push_o;
  assign out_valid_o = head_valid && !redirect_valid_i;

  // pc leaving its line pops the head
  assign line_step = (next_line != pc_line);
  assign buf_pop_o = out_fire && line_step;

  // jal target beyond the following line, the prefetched lines are useless
  assign jump_away   = out_fire && line_step && (next_line != pc_line + 1'b1);
  assign flush       = redirect_valid_i || jump_away;
  assign buf_flush_o = flush;

  assign out_o.pc   = pc_q;
  assign out_o.inst = sel_inst_i;
  assign out_o.err  = head_err_i;
  assign pc_o       = pc_q;

  // ==============================
  // pc and prefetch address
  // ==============================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q       <= RESET_PC;
      req_line_q <= RESET_PC[ADDR_W-1:OFFSET_W];
    end else if (redirect_valid_i) begin
      pc_q       <= redirect_pc_i;
      req_line_q <= redirect_pc_i[ADDR_W-1:OFFSET_W];
    end else begin
      if (out_fire) begin
        pc_q <= next_pc_i;
      end
      if (jump_away) begin
        req_line_q <= next_line;
      end else if (req_raise) begin
        req_line_q <= req_line_q + 1'b1;
      end
    end
  end

  // ==============================
  // request FSM
  // ==============================

  // one request in flight at most, never on a flush cycle
  assign req_raise = (state_q == S_IDLE) && !req_valid_q && !buf_full_i && !flush;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q     <= S_IDLE;
      req_valid_q <= 1'b0;
      stale_q     <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req_fire) begin
            state_q     <= S_WAIT_RESP;
            req_valid_q <= 1'b0;
          end else if (req_raise) begin
            req_valid_q <= 1'b1;
          end
        end
        S_WAIT_RESP: begin
          if (resp_fire) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase

      // anything still in flight after a flush belongs to the old stream
      if (flush) begin
        stale_q <= req_valid_q || ((state_q == S_WAIT_RESP) && !resp_fire);
      end else if (resp_fire) begin
        stale_q <= 1'b0;
      end
    end
  end

  // payload latched once, held until the transfer
  always_ff @(posedge clk) begin
    if (req_raise) begin
      req_q.line_addr <= req_line_q;
    end
  end

  assign req_valid_o  = req_valid_q;
  assign req_o        = req_q;
  assign resp_ready_o = (state_q == S_WAIT_RESP);

  // ==============================
  // checks
  // ==============================

  req_hold_a : assert property (@(posedge clk) disable iff (rst_n)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

  push_not_full_a : assert property (@(posedge clk) disable iff (rst_n)
    !(buf_push_o && buf_full_i));

endmodule

// File: source/fetch_top.sv
module fetch_top import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  output logic              req_valid_o,
  input  logic              req_ready_i,
  output line_req_t         req_o,
  input  logic              resp_valid_i,
  output logic              resp_ready_o,
  input  line_resp_t        resp_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output fetch_out_t        out_o,
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i
);

  logic              buf_push;
  logic              buf_pop;
  logic              buf_flush;
  logic              buf_full;
  logic              buf_empty;
  logic [LINE_W-1:0] head_line;
  logic              head_err;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] next_pc;
  logic [31:0]       sel_inst;

  // pc, handshakes and buffer control
  fetch_ctrl fetch_ctrl_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_o      (req_valid_o),
    .req_ready_i      (req_ready_i),
    .req_o            (req_o),
    .resp_valid_i     (resp_valid_i),
    .resp_ready_o     (resp_ready_o),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_o            (out_o),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .buf_push_o       (buf_push),
    .buf_pop_o        (buf_pop),
    .buf_flush_o      (buf_flush),
    .buf_full_i       (buf_full),
    .buf_empty_i      (buf_empty),
    .head_err_i       (head_err),
    .next_pc_i        (next_pc),
    .sel_inst_i       (sel_inst),
    .pc_o             (pc)
  );

  // response lines land here directly
  line_buffer line_buffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (buf_push),
    .push_line_i (resp_i),
    .pop_i       (buf_pop),
    .flush_i     (buf_flush),
    .full_o      (buf_full),
    .empty_o     (buf_empty),
    .head_line_o (head_line),
    .head_err_o  (head_err)
  );

  inst_select inst_select_i (
    .pc_i      (pc),
    .line_i    (head_line),
    .inst_o    (sel_inst),
    .next_pc_o (next_pc)
  );

endmodule

// File: dv/tb_clock.sv
module tb_clock (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  localparam int HALF_PERIOD = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

// File: dv/line_mem_model.sv
module line_mem_model import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  line_req_t  req_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output line_resp_t resp_o,
  // line being served and its contents by the memory rule
  output line_req_t  serve_o,
  input  line_resp_t line_i
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] lfsr = 32'haff6_cb82;
  logic        busy;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  initial begin
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_o       = '0;
    serve_o      = '0;
    busy         = 1'b0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      req_ready_o  <= 1'b0;
      resp_valid_o <= 1'b0;
      busy         <= 1'b0;
    end else if (!busy) begin
      if (req_valid_i && req_ready_o) begin
        busy        <= 1'b1;
        req_ready_o <= 1'b0;
        serve_o     <= req_i;
      end else begin
        req_ready_o <= rand_bit();
      end
    end else if (!resp_valid_o) begin
      // random latency, one coin per cycle
      if (rand_bit()) begin
        resp_valid_o <= 1'b1;
        resp_o       <= line_i;
      end
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;
      busy         <= 1'b0;
    end
  end

endmodule

// File: dv/fetch_tb.sv
module fetch_tb import fetch_pkg::*, rv_inst_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TESTS  = 5;
  // generous cycle bound for one directed test
  localparam int TEST_BOUND = 1000;

  // jal table and error window
  localparam logic [ADDR_W-1:0] JAL_A0   = 32'h8000_0030;
  localparam logic [ADDR_W-1:0] JAL_T0   = 32'h8000_0130;
  localparam logic [ADDR_W-1:0] JAL_A1   = 32'h8000_0150;
  localparam logic [ADDR_W-1:0] JAL_T1   = 32'h8000_0010;
  localparam logic [ADDR_W-1:0] ERR_LINE = 32'h8000_0800;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic              req_ready;
  line_req_t         req;
  logic              resp_valid;
  logic              resp_ready;
  line_resp_t        resp;
  logic              out_valid;
  logic              out_ready;
  fetch_out_t        fetch_out;
  logic              redirect_valid;
  logic [ADDR_W-1:0] redirect_pc;
  line_req_t         serve_line;
  line_resp_t        mem_line;

  logic [31:0]       lfsr = 32'haff6_cb82;
  logic [ADDR_W-1:0] exp_pc;
  logic              was_stalled;
  logic              in_flight;
  int                n_out;
  int                errors;
  int                failed_tests;

  tb_clock clock_i (.clk_o(clk));

  line_mem_model mem_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_o       (resp),
    .serve_o      (serve_line),
    .line_i       (mem_line)
  );

  fetch_top fetch_top_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_o      (req_valid),
    .req_ready_i      (req_ready),
    .req_o            (req),
    .resp_valid_i     (resp_valid),
    .resp_ready_o     (resp_ready),
    .resp_i           (resp),
    .out_valid_o      (out_valid),
    .out_ready_i      (out_ready),
    .out_o            (fetch_out),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc)
  );

  // ==============================
  // memory rule and prediction
  // ==============================

  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // jal x1 with a byte offset
  function automatic logic [31:0] jal_word(input logic [ADDR_W-1:0] off);
    inst_word_u w;
    w.jal.imm20    = off[20];
    w.jal.imm10_1  = off[10:1];
    w.jal.imm11    = off[11];
    w.jal.imm19_12 = off[19:12];
    w.jal.rd       = 5'd1;
    w.jal.opcode   = OP_JAL;
    return w;
  endfunction

  function automatic logic [31:0] word_at(input logic [ADDR_W-1:0] a);
    if (a == JAL_A0) begin
      return jal_word(JAL_T0 - JAL_A0);
    end
    if (a == JAL_A1) begin
      return jal_word(JAL_T1 - JAL_A1);
    end
    // addi with imm a[13:2] and registers folded from the upper bits
    return {a[13:2], a[23:19] ^ {2'b00, a[31:29]}, 3'b000, a[18:14] ^ a[28:24], OP_IMM};
  endfunction

  function automatic logic err_at(input logic [ADDR_W-1:0] a);
    return a[ADDR_W-1:OFFSET_W] == ERR_LINE[ADDR_W-1:OFFSET_W];
  endfunction

  function automatic line_resp_t line_at(input line_req_t l);
    line_resp_t r;
    r.resp = err_at({l.line_addr, 4'h0}) ? 2'b10 : 2'b00;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      r.data[32*w +: 32] = word_at({l.line_addr, 4'(w * 4)});
    end
    return r;
  endfunction

  assign mem_line = line_at(serve_line);

  function automatic logic [ADDR_W-1:0] next_expected(input logic [ADDR_W-1:0] pc);
    if (pc == JAL_A0) begin
      return JAL_T0;
    end
    if (pc == JAL_A1) begin
      return JAL_T1;
    end
    return pc + 32'd4;
  endfunction

  function automatic fetch_out_t expect_at(input logic [ADDR_W-1:0] pc);
    fetch_out_t e;
    e.pc   = pc;
    e.inst = word_at(pc);
    e.err  = err_at(pc);
    return e;
  endfunction

  // ==============================
  // compare tasks
  // ==============================

  task automatic check_out(input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED out_o: got pc %h inst %h err %h, expected pc %h inst %h err %h",
               got.pc, got.inst, got.err, exp.pc, exp.inst, exp.err);
      errors++;
    end
  endtask

  task automatic check_req(input line_req_t got, input line_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED req_o: got %h, expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ==============================
  // stream helpers
  // ==============================

  // one line request in flight between the two transfers
  always @(posedge clk) begin
    if (rst_n) begin
      in_flight <= 1'b0;
    end else if (req_valid && req_ready) begin
      in_flight <= 1'b1;
    end else if (resp_valid) begin
      in_flight <= 1'b0;
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      check_flag("resp_ready_o", resp_ready, in_flight);
    end
  end

  // negedge view, a valid and ready pair here transfers on the next edge
  task automatic watch_out();
    if (was_stalled && !out_valid) begin
      $display("out_valid_o dropped while stalled at pc %h", exp_pc);
      errors++;
    end
    if (out_valid) begin
      check_out(fetch_out, expect_at(exp_pc));
      if (out_ready) begin
        exp_pc = next_expected(exp_pc);
        n_out++;
      end
    end
    was_stalled = out_valid && !out_ready;
  endtask

  task automatic out_cycle(input logic random_ready);
    logic rdy;
    rdy = random_ready ? rand_bit() : 1'b1;
    @(posedge clk);
    out_ready <= rdy;
    @(negedge clk);
    watch_out();
  endtask

  task automatic collect(input int n, input logic random_ready);
    int target;
    target = n_out + n;
    while (n_out < target) begin
      out_cycle(random_ready);
    end
    @(posedge clk);
    out_ready <= 1'b0;
  endtask

  task automatic redirect_to(input logic [ADDR_W-1:0] pc);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= pc;
    out_ready      <= 1'b0;
    @(negedge clk);
    if (out_valid) begin
      $display("out_valid_o was high during the redirect to %h", pc);
      errors++;
    end
    exp_pc      = pc;
    was_stalled = 1'b0;
    @(posedge clk);
    redirect_valid <= 1'b0;
  endtask

  task automatic end_test(input string name, input int start);
    if (errors == start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d checks failed", name, errors - start);
      failed_tests++;
    end
  endtask

  // ==============================
  // directed tests
  // ==============================

  task automatic first_fetch();
    int        start;
    line_req_t exp_req;
    start             = errors;
    exp_req.line_addr = RESET_PC[ADDR_W-1:OFFSET_W];
    // last reset cycle, then the request in the first cycle after it
    @(negedge clk);
    check_flag("req_valid_o", req_valid, 1'b0);
    @(negedge clk);
    check_flag("req_valid_o", req_valid, 1'b1);
    check_req(req, exp_req);
    collect(12, 1'b0);
    end_test("first_fetch", start);
  endtask

  // forward jal, then a backward one into the first lines
  task automatic jal_follow();
    int start;
    start = errors;
    collect(12, 1'b0);
    end_test("jal_follow", start);
  endtask

  task automatic stale_redirect();
    int start;
    start = errors;
    // stream until a line response is outstanding
    do begin
      out_cycle(1'b0);
    end while (!(resp_ready && !resp_valid));
    redirect_to(32'h8000_0400);
    collect(8, 1'b0);
    end_test("stale_redirect", start);
  endtask

  // runs through both jal entries under random stalls
  task automatic random_stalls();
    int start;
    start = errors;
    redirect_to(RESET_PC + 32'h20);
    collect(40, 1'b1);
    end_test("random_stalls", start);
  endtask

  task automatic error_line();
    int start;
    start = errors;
    redirect_to(ERR_LINE - 32'h10);
    collect(12, 1'b0);
    end_test("error_line", start);
  endtask

  // ==============================
  // main sequence and watchdog
  // ==============================

  initial begin
    rst_n          = 1'b1;
    out_ready      = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    exp_pc         = RESET_PC;
    was_stalled    = 1'b0;
    n_out          = 0;
    errors         = 0;
    failed_tests   = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b0;
    first_fetch();
    jal_follow();
    stale_redirect();
    random_stalls();
    error_line();
    $display("%0d tests run, %0d tests failing, %0d checks failed",
             NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_BOUND * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: files.f
source/fetch_pkg.sv
source/rv_inst_pkg.sv
source/line_buffer.sv
source/inst_select.sv
source/fetch_ctrl.sv
source/fetch_top.sv
dv/tb_clock.sv
dv/line_mem_model.sv
dv/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
